// File: nand_params.svh
`ifndef NAND_PARAMS_SVH
`define NAND_PARAMS_SVH

// --------------------------------------------------
// Bus cycle and delay timing, in clocks
// --------------------------------------------------
`define T_SETUP 1
`define T_PULSE 2
`define T_HOLD 1
// Wait after last write before R/B# is sampled
`define T_WB 8
// READ STATUS command to data read
`define T_WHR 6

// NAND opcodes
`define NAND_CMD_RESET 8'hFF
`define NAND_CMD_READ_ID 8'h90
`define NAND_CMD_READ_STATUS 8'h70
`define NAND_CMD_ERASE1 8'h60
`define NAND_CMD_ERASE2 8'hD0

// --------------------------------------------------
// Host command numbers
// --------------------------------------------------
`define OP_NAND_RESET 5'd1
`define OP_READ_ID 5'd3
`define OP_BLOCK_ERASE 5'd4
`define OP_READ_STATUS 5'd5
`define OP_GET_STATUS 5'd8
`define OP_CHIP_ENABLE 5'd9
`define OP_CHIP_DISABLE 5'd10
`define OP_WRITE_PROTECT 5'd11
`define OP_WRITE_ENABLE 5'd12
`define OP_RESET_INDEX 5'd13
`define OP_GET_ID_BYTE 5'd14
`define OP_GET_ADDR_BYTE 5'd18
`define OP_SET_ADDR_BYTE 5'd19

// Bus cycle kinds
`define CYC_CMD 2'd0
`define CYC_ADDR 2'd1
`define CYC_WRITE 2'd2
`define CYC_READ 2'd3

// Buffer sizes
`define ID_BYTES 5
`define ADDR_BYTES 5

// Wishbone register map
`define REG_CMD 2'd0
`define REG_DATA_IN 2'd1
`define REG_STATUS 2'd2
`define REG_DATA_OUT 2'd3

`endif

// File: nand_pkg.sv
package nand_pkg;

	// --------------------------------------------------
	// Vector types
	// --------------------------------------------------
	// One NAND or host data byte
	typedef logic [7:0] byte_t;
	// Host command number
	typedef logic [4:0] op_code_t;
	// Bus cycle type
	typedef logic [1:0] cycle_kind_t;
	// Clock countdown
	typedef logic [15:0] delay_t;
	// Shared index register
	typedef logic [2:0] idx_t;
	// Address bytes 2 to 4, byte 2 in the low byte
	typedef logic [23:0] row_addr_t;
	// Wishbone register address
	typedef logic [1:0] wb_addr_t;

	// --------------------------------------------------
	// State machines
	// --------------------------------------------------
	// Sequencer, NEXT looks up the step and dispatches
	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_NEXT,
		SEQ_CYCLE,
		SEQ_DELAY,
		SEQ_RNB
	} seq_state_t;

	// Phases of one bus cycle
	typedef enum logic [1:0] {
		CS_IDLE,
		CS_SETUP,
		CS_PULSE,
		CS_HOLD
	} cycle_state_t;

endpackage

// File: nand_host_decode.sv
`timescale 1ns/1ps
`include "nand_params.svh"

module nand_host_decode (
	input logic clk,
	input logic nreset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input nand_pkg::wb_addr_t wb_adr,
	input nand_pkg::byte_t wb_dat_w,
	input logic busy,
	input nand_pkg::byte_t status,
	input nand_pkg::byte_t data_out,
	output nand_pkg::byte_t wb_dat_r,
	output logic wb_ack,
	output logic nand_start,
	output logic local_start,
	output nand_pkg::op_code_t op,
	output nand_pkg::byte_t data_in
);
	import nand_pkg::*;

	logic cmd_wr;
	logic take;
	logic is_nand_op;
	logic is_local_op;
	op_code_t new_op;
	byte_t rd_mux;

	// Command write on the bus this cycle
	assign cmd_wr = wb_we && (wb_adr == `REG_CMD);
	assign new_op = wb_dat_w[4:0];

	// Accept once per strobe, hold off commands while the sequencer runs
	assign take = wb_cyc && wb_stb && !wb_ack && !(cmd_wr && busy);

	// Sort command numbers, anything else is acked and dropped
	always_comb begin
		is_nand_op = 1'b0;
		is_local_op = 1'b0;
		case (new_op)
			`OP_NAND_RESET, `OP_READ_ID, `OP_BLOCK_ERASE, `OP_READ_STATUS:
				is_nand_op = 1'b1;
			`OP_GET_STATUS, `OP_CHIP_ENABLE, `OP_CHIP_DISABLE,
			`OP_WRITE_PROTECT, `OP_WRITE_ENABLE, `OP_RESET_INDEX,
			`OP_GET_ID_BYTE, `OP_GET_ADDR_BYTE, `OP_SET_ADDR_BYTE:
				is_local_op = 1'b1;
			default: ;
		endcase
	end

	// Read data select
	always_comb begin
		case (wb_adr)
			`REG_STATUS: rd_mux = status;
			`REG_DATA_OUT: rd_mux = data_out;
			default: rd_mux = 8'h00;
		endcase
	end

	// --------------------------------------------------
	// Ack and op strobes, all in the cycle after accept
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			wb_ack <= 1'b0;
			nand_start <= 1'b0;
			local_start <= 1'b0;
		end else begin
			wb_ack <= take;
			nand_start <= take && cmd_wr && is_nand_op;
			local_start <= take && cmd_wr && is_local_op;
		end
	end

	// Data registers
	always_ff @(posedge clk) begin
		if (take && cmd_wr)
			op <= new_op;
		if (take && wb_we && (wb_adr == `REG_DATA_IN))
			data_in <= wb_dat_w;
		if (take && !wb_we)
			wb_dat_r <= rd_mux;
	end

endmodule

// File: nand_op_sequencer.sv
`timescale 1ns/1ps
`include "nand_params.svh"

module nand_op_sequencer (
	input logic clk,
	input logic nreset,
	input logic nand_start,
	input nand_pkg::op_code_t op,
	input nand_pkg::row_addr_t row_addr,
	input logic nand_rnb,
	input logic cycle_done,
	input nand_pkg::byte_t cycle_rd_byte,
	output logic busy,
	output logic cycle_start,
	output nand_pkg::cycle_kind_t cycle_kind,
	output nand_pkg::byte_t cycle_byte,
	output logic id_wr,
	output nand_pkg::idx_t id_idx,
	output logic status_wr,
	output nand_pkg::byte_t rd_byte
);
	import nand_pkg::*;

	// Step of the first ID read in the READ ID list
	localparam logic [3:0] ID_FIRST_STEP = 4'd3;

	seq_state_t state;
	op_code_t op_r;
	logic [3:0] step;
	delay_t delay_cnt;

	// Decoded current step
	seq_state_t step_state;
	cycle_kind_t step_kind;
	byte_t step_byte;
	delay_t step_delay;

	assign busy = (state != SEQ_IDLE);

	// --------------------------------------------------
	// Step lists, one per NAND op
	// --------------------------------------------------
	always_comb begin
		step_state = SEQ_IDLE;
		step_kind = `CYC_CMD;
		step_byte = 8'h00;
		step_delay = 16'd0;
		case (op_r)
			`OP_NAND_RESET: begin
				case (step)
					4'd0: begin
						step_state = SEQ_CYCLE;
						step_byte = `NAND_CMD_RESET;
					end
					4'd1: begin
						step_state = SEQ_DELAY;
						step_delay = delay_t'(`T_WB);
					end
					4'd2: step_state = SEQ_RNB;
					default: ;
				endcase
			end
			`OP_READ_ID: begin
				case (step)
					4'd0: begin
						step_state = SEQ_CYCLE;
						step_byte = `NAND_CMD_READ_ID;
					end
					// Single address byte 00h
					4'd1: begin
						step_state = SEQ_CYCLE;
						step_kind = `CYC_ADDR;
					end
					4'd2: begin
						step_state = SEQ_DELAY;
						step_delay = delay_t'(`T_WB);
					end
					// Five ID reads
					4'd3, 4'd4, 4'd5, 4'd6, 4'd7: begin
						step_state = SEQ_CYCLE;
						step_kind = `CYC_READ;
					end
					default: ;
				endcase
			end
			`OP_READ_STATUS: begin
				case (step)
					4'd0: begin
						step_state = SEQ_CYCLE;
						step_byte = `NAND_CMD_READ_STATUS;
					end
					4'd1: begin
						step_state = SEQ_DELAY;
						step_delay = delay_t'(`T_WHR);
					end
					4'd2: begin
						step_state = SEQ_CYCLE;
						step_kind = `CYC_READ;
					end
					default: ;
				endcase
			end
			`OP_BLOCK_ERASE: begin
				case (step)
					4'd0: begin
						step_state = SEQ_CYCLE;
						step_byte = `NAND_CMD_ERASE1;
					end
					// Row address, low byte first
					4'd1, 4'd2, 4'd3: begin
						step_state = SEQ_CYCLE;
						step_kind = `CYC_ADDR;
						step_byte = row_addr[(step - 4'd1) * 8 +: 8];
					end
					4'd4: begin
						step_state = SEQ_CYCLE;
						step_byte = `NAND_CMD_ERASE2;
					end
					4'd5: begin
						step_state = SEQ_DELAY;
						step_delay = delay_t'(`T_WB);
					end
					4'd6: step_state = SEQ_RNB;
					default: ;
				endcase
			end
			default: ;
		endcase
	end

	// --------------------------------------------------
	// Execute FSM
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			state <= SEQ_IDLE;
			step <= 4'd0;
			cycle_start <= 1'b0;
			id_wr <= 1'b0;
			status_wr <= 1'b0;
		end else begin
			// Strobes last one clock
			cycle_start <= 1'b0;
			id_wr <= 1'b0;
			status_wr <= 1'b0;
			case (state)
				SEQ_IDLE: begin
					if (nand_start) begin
						step <= 4'd0;
						state <= SEQ_NEXT;
					end
				end
				SEQ_NEXT: begin
					state <= step_state;
					if (step_state == SEQ_CYCLE)
						cycle_start <= 1'b1;
				end
				SEQ_CYCLE: begin
					if (cycle_done) begin
						// Post read bytes to ID buffer or data_out
						if (cycle_kind == `CYC_READ) begin
							if (op_r == `OP_READ_ID)
								id_wr <= 1'b1;
							else
								status_wr <= 1'b1;
						end
						step <= step + 4'd1;
						state <= SEQ_NEXT;
					end
				end
				SEQ_DELAY: begin
					if (delay_cnt <= 16'd1) begin
						step <= step + 4'd1;
						state <= SEQ_NEXT;
					end
				end
				SEQ_RNB: begin
					// Chip ready again
					if (nand_rnb) begin
						step <= step + 4'd1;
						state <= SEQ_NEXT;
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	// Op, cycle and result data
	always_ff @(posedge clk) begin
		if (state == SEQ_IDLE && nand_start)
			op_r <= op;
		if (state == SEQ_NEXT) begin
			cycle_kind <= step_kind;
			cycle_byte <= step_byte;
			delay_cnt <= step_delay;
		end else if (state == SEQ_DELAY) begin
			delay_cnt <= delay_cnt - 16'd1;
		end
		if (state == SEQ_CYCLE && cycle_done) begin
			rd_byte <= cycle_rd_byte;
			id_idx <= idx_t'(step - ID_FIRST_STEP);
		end
	end

endmodule

// File: nand_bus_cycle.sv
`timescale 1ns/1ps
`include "nand_params.svh"

module nand_bus_cycle (
	input logic clk,
	input logic nreset,
	input logic cycle_start,
	input nand_pkg::cycle_kind_t cycle_kind,
	input nand_pkg::byte_t cycle_byte,
	input nand_pkg::byte_t nand_dq_in,
	output logic cycle_done,
	output nand_pkg::byte_t cycle_rd_byte,
	output logic nand_cle,
	output logic nand_ale,
	output logic nand_nwe,
	output logic nand_nre,
	output nand_pkg::byte_t nand_dq_out,
	output logic nand_dq_oe
);
	import nand_pkg::*;

	cycle_state_t state;
	cycle_kind_t kind;
	// Clocks left in the current phase
	logic [3:0] phase_cnt;

	// Last hold clock ends the cycle
	assign cycle_done = (state == CS_HOLD) && (phase_cnt == 4'd0);

	always_ff @(posedge clk) begin
		if (!nreset) begin
			state <= CS_IDLE;
			phase_cnt <= 4'd0;
			nand_cle <= 1'b0;
			nand_ale <= 1'b0;
			nand_nwe <= 1'b1;
			nand_nre <= 1'b1;
			nand_dq_oe <= 1'b0;
		end else begin
			case (state)
				CS_IDLE: begin
					if (cycle_start) begin
						state <= CS_SETUP;
						phase_cnt <= 4'(`T_SETUP - 1);
						// Latch enables held for the whole cycle
						nand_cle <= (cycle_kind == `CYC_CMD);
						nand_ale <= (cycle_kind == `CYC_ADDR);
						// Drive the bus on all but reads
						nand_dq_oe <= (cycle_kind != `CYC_READ);
					end
				end
				CS_SETUP: begin
					if (phase_cnt == 4'd0) begin
						state <= CS_PULSE;
						phase_cnt <= 4'(`T_PULSE - 1);
						nand_nwe <= (kind == `CYC_READ);
						nand_nre <= (kind != `CYC_READ);
					end else begin
						phase_cnt <= phase_cnt - 4'd1;
					end
				end
				CS_PULSE: begin
					if (phase_cnt == 4'd0) begin
						state <= CS_HOLD;
						phase_cnt <= 4'(`T_HOLD - 1);
						nand_nwe <= 1'b1;
						nand_nre <= 1'b1;
					end else begin
						phase_cnt <= phase_cnt - 4'd1;
					end
				end
				CS_HOLD: begin
					if (phase_cnt == 4'd0) begin
						state <= CS_IDLE;
						nand_cle <= 1'b0;
						nand_ale <= 1'b0;
						nand_dq_oe <= 1'b0;
					end else begin
						phase_cnt <= phase_cnt - 4'd1;
					end
				end
				default: state <= CS_IDLE;
			endcase
		end
	end

	// Cycle data, read byte sampled on last pulse clock
	always_ff @(posedge clk) begin
		if (state == CS_IDLE && cycle_start) begin
			kind <= cycle_kind;
			nand_dq_out <= cycle_byte;
		end
		if (state == CS_PULSE && phase_cnt == 4'd0 && kind == `CYC_READ)
			cycle_rd_byte <= nand_dq_in;
	end

endmodule

// File: nand_result_regs.sv
`timescale 1ns/1ps
`include "nand_params.svh"

module nand_result_regs (
	input logic clk,
	input logic nreset,
	input logic local_start,
	input nand_pkg::op_code_t op,
	input nand_pkg::byte_t data_in,
	input logic busy,
	input logic id_wr,
	input nand_pkg::idx_t id_idx,
	input logic status_wr,
	input nand_pkg::byte_t rd_byte,
	output nand_pkg::byte_t status,
	output nand_pkg::byte_t data_out,
	output nand_pkg::row_addr_t row_addr,
	output logic nand_nce,
	output logic nand_nwp
);
	import nand_pkg::*;

	idx_t idx;
	logic oob;
	byte_t id_buf [`ID_BYTES];
	byte_t addr_bytes [`ADDR_BYTES];
	logic id_ok;
	logic addr_ok;
	logic idx_ok;

	// Status: 7 busy, 4 index out of bounds, 3 write protected, 2 chip enabled
	assign status = {busy, 2'b00, oob, ~nand_nwp, ~nand_nce, 2'b00};

	// Erase row from address bytes 2 to 4
	assign row_addr = {addr_bytes[4], addr_bytes[3], addr_bytes[2]};

	// Index bounds per buffer
	assign id_ok = (idx < 3'(`ID_BYTES));
	assign addr_ok = (idx < 3'(`ADDR_BYTES));
	assign idx_ok = (op == `OP_GET_ID_BYTE) ? id_ok : addr_ok;

	// --------------------------------------------------
	// Local ops and buffers
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			// Start disabled and write protected
			nand_nce <= 1'b1;
			nand_nwp <= 1'b0;
			idx <= 3'd0;
			oob <= 1'b0;
			for (int i = 0; i < `ID_BYTES; i++)
				id_buf[i] <= 8'h00;
			for (int i = 0; i < `ADDR_BYTES; i++)
				addr_bytes[i] <= 8'h00;
		end else begin
			// ID bytes from the sequencer
			if (id_wr)
				id_buf[id_idx] <= rd_byte;
			if (local_start) begin
				case (op)
					`OP_CHIP_ENABLE: nand_nce <= 1'b0;
					`OP_CHIP_DISABLE: nand_nce <= 1'b1;
					`OP_WRITE_PROTECT: nand_nwp <= 1'b0;
					`OP_WRITE_ENABLE: nand_nwp <= 1'b1;
					`OP_RESET_INDEX: idx <= 3'd0;
					`OP_GET_ID_BYTE, `OP_GET_ADDR_BYTE, `OP_SET_ADDR_BYTE: begin
						if (idx_ok) begin
							if (op == `OP_SET_ADDR_BYTE)
								addr_bytes[idx] <= data_in;
							idx <= idx + 3'd1;
							oob <= 1'b0;
						end else begin
							// Past the end, wrap and flag
							idx <= 3'd0;
							oob <= 1'b1;
						end
					end
					default: ;
				endcase
			end
		end
	end

	// Host read-back register
	always_ff @(posedge clk) begin
		if (status_wr) begin
			data_out <= rd_byte;
		end else if (local_start) begin
			case (op)
				`OP_GET_STATUS: data_out <= status;
				`OP_GET_ID_BYTE: data_out <= id_ok ? id_buf[idx] : 8'h00;
				`OP_GET_ADDR_BYTE: data_out <= addr_ok ? addr_bytes[idx] : 8'h00;
				default: ;
			endcase
		end
	end

endmodule

// File: nand_master.sv
`timescale 1ns/1ps

module nand_master (
	input logic clk,
	input logic nreset,
	// Host side, Wishbone classic
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input nand_pkg::wb_addr_t wb_adr,
	input nand_pkg::byte_t wb_dat_w,
	output nand_pkg::byte_t wb_dat_r,
	output logic wb_ack,
	// NAND pins
	output logic nand_cle,
	output logic nand_ale,
	output logic nand_nwe,
	output logic nand_nre,
	output logic nand_nce,
	output logic nand_nwp,
	input logic nand_rnb,
	output nand_pkg::byte_t nand_dq_out,
	output logic nand_dq_oe,
	input nand_pkg::byte_t nand_dq_in
);
	import nand_pkg::*;

	// Host decode to execute stage and local registers
	logic nand_start;
	logic local_start;
	op_code_t op;
	byte_t data_in;
	logic busy;
	byte_t status;
	byte_t data_out;

	// Sequencer to bus cycle engine
	logic cycle_start;
	cycle_kind_t cycle_kind;
	byte_t cycle_byte;
	logic cycle_done;
	byte_t cycle_rd_byte;

	// Sequencer results and current address
	logic id_wr;
	idx_t id_idx;
	logic status_wr;
	byte_t rd_byte;
	row_addr_t row_addr;

	// Wishbone slave and command sorting
	nand_host_decode u_host_decode (.*);

	// Runs NAND commands as bus cycle lists
	nand_op_sequencer u_op_sequencer (.*);

	// Drives CLE, ALE, WE#, RE# and the data bus
	nand_bus_cycle u_bus_cycle (.*);

	// Local ops, status, buffers and CE#/WP#
	nand_result_regs u_result_regs (.*);

endmodule

// File: tb_nand_chip_model.sv
`timescale 1ns/1ps
`include "nand_params.svh"

module tb_nand_chip_model (
	input logic clk,
	input logic nreset,
	input logic nand_cle,
	input logic nand_ale,
	input logic nand_nwe,
	input logic nand_nre,
	input logic nand_nce,
	input logic nand_nwp,
	input nand_pkg::byte_t nand_dq_out,
	input logic nand_dq_oe,
	output nand_pkg::byte_t nand_dq_in,
	output logic nand_rnb,
	output logic protocol_err
);
	import nand_pkg::*;

	// Array busy times, in clocks
	localparam int ERASE_CLKS = 300;
	localparam int RESET_CLKS = 20;

	// Last opcode and erase row, read by the testbench
	byte_t last_cmd = 8'h00;
	row_addr_t erase_row = '0;

	int busy_cnt = 0;
	int addr_cnt = 0;
	int id_ptr = 0;
	logic id_mode = 1'b0;
	logic err_seen = 1'b0;
	// Strobe levels from the previous clock
	logic nwe_q = 1'b1;
	logic nre_q = 1'b1;

	// Fixed ID string of this chip
	function automatic byte_t id_byte(input int i);
		case (i)
			0: return 8'hA1;
			1: return 8'hB2;
			2: return 8'hC3;
			3: return 8'hD4;
			4: return 8'hE5;
			default: return 8'h00;
		endcase
	endfunction

	// Ready once the busy count runs out
	assign nand_rnb = (busy_cnt == 0);
	assign protocol_err = err_seen;

	// ID bytes after 90h, status byte otherwise, bit 7 follows WP#
	assign nand_dq_in = id_mode ? id_byte(id_ptr) : (nand_nwp ? 8'hE0 : 8'h60);

	// --------------------------------------------------
	// Pin watcher, sampled on the controller clock
	// --------------------------------------------------
	always @(posedge clk) begin
		nwe_q <= nand_nwe;
		nre_q <= nand_nre;
		if (!nreset) begin
			busy_cnt <= 0;
			addr_cnt <= 0;
			id_ptr <= 0;
			id_mode <= 1'b0;
			last_cmd <= 8'h00;
			erase_row <= '0;
		end else begin
			if (busy_cnt != 0)
				busy_cnt <= busy_cnt - 1;
			// Protocol checks
			if (nand_cle && nand_ale) begin
				$display("NAND model saw CLE and ALE high together at %0t", $time);
				err_seen <= 1'b1;
			end
			if (nand_nce && (!nand_nwe || !nand_nre)) begin
				$display("NAND model saw a bus cycle while CE# was high at %0t", $time);
				err_seen <= 1'b1;
			end
			// Latch on the rising edge of WE#
			if (!nwe_q && nand_nwe) begin
				if (!nand_dq_oe) begin
					$display("NAND model saw a write with the data bus undriven at %0t", $time);
					err_seen <= 1'b1;
				end
				if (nand_cle) begin
					last_cmd <= nand_dq_out;
					case (nand_dq_out)
						`NAND_CMD_RESET: begin
							busy_cnt <= RESET_CLKS;
							id_mode <= 1'b0;
						end
						`NAND_CMD_READ_ID: begin
							id_mode <= 1'b1;
							id_ptr <= 0;
						end
						`NAND_CMD_READ_STATUS: id_mode <= 1'b0;
						`NAND_CMD_ERASE1: addr_cnt <= 0;
						`NAND_CMD_ERASE2: busy_cnt <= ERASE_CLKS;
						default: ;
					endcase
				end else if (nand_ale && last_cmd == `NAND_CMD_ERASE1 && addr_cnt < 3) begin
					// Row bytes arrive low byte first
					erase_row[addr_cnt * 8 +: 8] <= nand_dq_out;
					addr_cnt <= addr_cnt + 1;
				end
			end
			// Next ID byte after each RE# pulse
			if (!nre_q && nand_nre && id_mode)
				id_ptr <= id_ptr + 1;
		end
	end

endmodule

// File: tb_nand_master.sv
`timescale 1ns/1ps
`include "nand_params.svh"

module tb_nand_master;
	import nand_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int DRIVE_DLY = 1;
	localparam int RESET_CYCLES = 16;
	// Ack wait for a plain access, and for a command held off by an erase
	localparam int ACK_WAIT = 8;
	localparam int ERASE_WAIT = 1000;
	// Twice the 2000 clocks that the tests need at most
	localparam int WATCHDOG_NS = 2 * 2000 * CLK_PERIOD;

	logic clk;
	logic nreset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	wb_addr_t wb_adr;
	byte_t wb_dat_w;
	byte_t wb_dat_r;
	logic wb_ack;
	logic nand_cle;
	logic nand_ale;
	logic nand_nwe;
	logic nand_nre;
	logic nand_nce;
	logic nand_nwp;
	logic nand_rnb;
	byte_t nand_dq_out;
	logic nand_dq_oe;
	byte_t nand_dq_in;
	logic protocol_err;

	integer seed;
	int error_count;
	// Address bytes last written through SET_ADDR_BYTE
	byte_t addr_bytes [`ADDR_BYTES];

	nand_master dut (.*);

	tb_nand_chip_model chip (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// --------------------------------------------------
	// Failure handling and compares
	// --------------------------------------------------
	task automatic abort_run();
		error_count++;
		$display("SOME TESTS FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic compare_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %02h expected %02h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %b expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic compare_row(input string name, input row_addr_t got, input row_addr_t exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %06h expected %06h", $time, name, got, exp);
			abort_run();
		end
	endtask

	// Status bits 7 busy, 4 index out of bounds, 3 write protected, 2 chip enabled
	function automatic byte_t expected_status(logic busy, logic oob, logic wp, logic ce);
		return {busy, 2'b00, oob, wp, ce, 2'b00};
	endfunction

	// --------------------------------------------------
	// Wishbone classic accesses
	// --------------------------------------------------
	task automatic bus_access(input wb_addr_t adr, input logic we, input byte_t wdat,
			output byte_t rdat, input int max_wait);
		int waited;
		logic got_ack;
		@(posedge clk);
		#DRIVE_DLY;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdat;
		waited = 0;
		do begin
			@(posedge clk);
			#DRIVE_DLY;
			waited++;
		end while (!wb_ack && waited < max_wait);
		got_ack = wb_ack;
		rdat = wb_dat_r;
		// Drop the strobe right after the ack
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		if (!got_ack) begin
			$display("No Wishbone ack within %0d clocks at address %0d", max_wait, adr);
			abort_run();
		end
	endtask

	task automatic wb_write(input wb_addr_t adr, input byte_t data, input int max_wait);
		byte_t unused;
		bus_access(adr, 1'b1, data, unused, max_wait);
	endtask

	task automatic wb_read(input wb_addr_t adr, output byte_t data);
		bus_access(adr, 1'b0, 8'h00, data, ACK_WAIT);
	endtask

	task automatic issue_cmd(input op_code_t op, input int max_wait = ACK_WAIT);
		wb_write(`REG_CMD, {3'b000, op}, max_wait);
	endtask

	task automatic check_reg(input wb_addr_t adr, input string name, input byte_t exp);
		byte_t value;
		wb_read(adr, value);
		compare_byte(name, value, exp);
	endtask

	// Poll status until the sequencer reports idle
	task automatic wait_idle();
		byte_t st;
		int polls;
		polls = 0;
		do begin
			wb_read(`REG_STATUS, st);
			polls++;
		end while (st[7] && polls < 200);
		if (st[7]) begin
			$display("Controller still busy after %0d status polls", polls);
			abort_run();
		end
	endtask

	// Loads all five address bytes with random values
	task automatic load_addr_bytes();
		issue_cmd(`OP_RESET_INDEX);
		for (int i = 0; i < `ADDR_BYTES; i++) begin
			addr_bytes[i] = byte_t'($random(seed));
			wb_write(`REG_DATA_IN, addr_bytes[i], ACK_WAIT);
			issue_cmd(`OP_SET_ADDR_BYTE);
		end
	endtask

	// --------------------------------------------------
	// Directed tests
	// --------------------------------------------------
	task automatic check_reset_state();
		check_reg(`REG_STATUS, "status", expected_status(1'b0, 1'b0, 1'b1, 1'b0));
		compare_bit("nand_nce", nand_nce, 1'b1);
		compare_bit("nand_nwp", nand_nwp, 1'b0);
		compare_bit("nand_nwe", nand_nwe, 1'b1);
		compare_bit("nand_nre", nand_nre, 1'b1);
		compare_bit("nand_dq_oe", nand_dq_oe, 1'b0);
	endtask

	task automatic toggle_chip_control();
		issue_cmd(`OP_CHIP_ENABLE);
		check_reg(`REG_STATUS, "status", expected_status(1'b0, 1'b0, 1'b1, 1'b1));
		compare_bit("nand_nce", nand_nce, 1'b0);
		issue_cmd(`OP_CHIP_DISABLE);
		check_reg(`REG_STATUS, "status", expected_status(1'b0, 1'b0, 1'b1, 1'b0));
		compare_bit("nand_nce", nand_nce, 1'b1);
		issue_cmd(`OP_WRITE_ENABLE);
		check_reg(`REG_STATUS, "status", expected_status(1'b0, 1'b0, 1'b0, 1'b0));
		compare_bit("nand_nwp", nand_nwp, 1'b1);
		issue_cmd(`OP_WRITE_PROTECT);
		check_reg(`REG_STATUS, "status", expected_status(1'b0, 1'b0, 1'b1, 1'b0));
		compare_bit("nand_nwp", nand_nwp, 1'b0);
	endtask

	task automatic walk_addr_bytes();
		load_addr_bytes();
		issue_cmd(`OP_RESET_INDEX);
		for (int i = 0; i < `ADDR_BYTES; i++) begin
			issue_cmd(`OP_GET_ADDR_BYTE);
			check_reg(`REG_DATA_OUT, "data_out", addr_bytes[i]);
		end
		// One past the end reads 0 and flags
		issue_cmd(`OP_GET_ADDR_BYTE);
		check_reg(`REG_DATA_OUT, "data_out", 8'h00);
		check_reg(`REG_STATUS, "status", expected_status(1'b0, 1'b1, 1'b1, 1'b0));
		// Index wrapped, so byte 0 again and the flag clears
		issue_cmd(`OP_GET_ADDR_BYTE);
		check_reg(`REG_DATA_OUT, "data_out", addr_bytes[0]);
		check_reg(`REG_STATUS, "status", expected_status(1'b0, 1'b0, 1'b1, 1'b0));
	endtask

	task automatic read_chip_id();
		byte_t id_exp;
		issue_cmd(`OP_CHIP_ENABLE);
		issue_cmd(`OP_READ_ID);
		wait_idle();
		compare_byte("chip.last_cmd", chip.last_cmd, `NAND_CMD_READ_ID);
		issue_cmd(`OP_RESET_INDEX);
		// ID string A1h to E5h in steps of 11h
		id_exp = 8'hA1;
		for (int i = 0; i < `ID_BYTES; i++) begin
			issue_cmd(`OP_GET_ID_BYTE);
			check_reg(`REG_DATA_OUT, "data_out", id_exp);
			id_exp = id_exp + 8'h11;
		end
		issue_cmd(`OP_GET_ID_BYTE);
		check_reg(`REG_DATA_OUT, "data_out", 8'h00);
		check_reg(`REG_STATUS, "status", expected_status(1'b0, 1'b1, 1'b1, 1'b1));
	endtask

	task automatic read_chip_status();
		// WP# low, so the chip reports protected
		issue_cmd(`OP_WRITE_PROTECT);
		issue_cmd(`OP_READ_STATUS);
		wait_idle();
		check_reg(`REG_DATA_OUT, "data_out", 8'h60);
		issue_cmd(`OP_WRITE_ENABLE);
		issue_cmd(`OP_READ_STATUS);
		wait_idle();
		check_reg(`REG_DATA_OUT, "data_out", 8'hE0);
		issue_cmd(`OP_NAND_RESET);
		wait_idle();
		compare_byte("chip.last_cmd", chip.last_cmd, `NAND_CMD_RESET);
	endtask

	task automatic erase_block();
		byte_t st;
		int waited;
		row_addr_t exp_row;
		load_addr_bytes();
		exp_row = {addr_bytes[4], addr_bytes[3], addr_bytes[2]};
		issue_cmd(`OP_BLOCK_ERASE);
		waited = 0;
		while (nand_rnb && waited < 100) begin
			@(posedge clk);
			#DRIVE_DLY;
			waited++;
		end
		if (nand_rnb) begin
			$display("R/B# never went low after the erase command");
			abort_run();
		end
		wb_read(`REG_STATUS, st);
		compare_bit("status[7]", st[7], 1'b1);
		compare_bit("nand_rnb", nand_rnb, 1'b0);
		// Held off until the array is ready again
		issue_cmd(`OP_GET_STATUS, ERASE_WAIT);
		compare_bit("nand_rnb", nand_rnb, 1'b1);
		compare_row("chip.erase_row", chip.erase_row, exp_row);
		compare_byte("chip.last_cmd", chip.last_cmd, `NAND_CMD_ERASE2);
		check_reg(`REG_DATA_OUT, "data_out", expected_status(1'b0, 1'b0, 1'b0, 1'b1));
	endtask

	// --------------------------------------------------
	// Main sequence, watchdog and model errors
	// --------------------------------------------------
	initial begin
		seed = 32'h02a1_eb8a;
		error_count = 0;
		clk = 1'b0;
		nreset = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		nreset = 1'b1;
		check_reset_state();
		toggle_chip_control();
		walk_addr_bytes();
		read_chip_id();
		read_chip_status();
		erase_block();
		if (error_count == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			abort_run();
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns with the tests unfinished", WATCHDOG_NS);
		abort_run();
	end

	// Model already printed what it saw
	always @(posedge protocol_err)
		abort_run();

endmodule

// File: vlog.f
+incdir+.
nand_pkg.sv
nand_host_decode.sv
nand_op_sequencer.sv
nand_bus_cycle.sv
nand_result_regs.sv
nand_master.sv
tb_nand_chip_model.sv
tb_nand_master.sv

// File: Makefile
TOOL = verilator
FLAGS = --binary --timing
TOP = tb_nand_master
FILELIST = vlog.f
LOG = sim.log

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
